// File: sim.f
+incdir+common
common/filt_types_pkg.sv
common/filt_ctrl_pkg.sv
filter_vm/filter_vm.sv
source/snoop_split.sv
source/fwd_combine.sv
source/parallel_filters.sv
test/parallel_filters_checker.sv
test/parallel_filters_tb.sv

// File: test/parallel_filters_tb.sv
`timescale 1ns/1ps
`include "filt_macros.svh"

module parallel_filters_tb;
	import filt_types_pkg::*;

	localparam int NUM_VMS  = `FILT_NUM_VMS;
	localparam int N_ACCEPT = 12;
	localparam int N_REJECT = 6;
	localparam int N_CHECK  = 20;
	localparam int N_PKTS   = N_ACCEPT + N_REJECT + N_CHECK + NUM_VMS;
	// 32 writes, 16 instructions at 2 cycles, 32 reads and 20 spare per packet, doubled
	localparam int CYCLE_LIMIT = 2 * N_PKTS * (32 + 2 * 16 + 32 + 20);

	logic       axi_aclk;
	logic       rst_n;
	code_addr_t code_mem_wr_addr;
	instr_t     code_mem_wr_data;
	logic       code_mem_wr_en;
	pkt_addr_t  snooper_wr_addr;
	pkt_data_t  snooper_wr_data;
	logic       snooper_wr_en;
	logic       snooper_done;
	logic       ready_for_snooper;
	pkt_addr_t  forwarder_rd_addr;
	logic       forwarder_rd_en;
	logic       forwarder_done;
	pkt_data_t  forwarder_rd_data;
	logic       ready_for_forwarder;
	pkt_len_t   len_to_forwarder;

	integer seed = 62454;
	int     cycles = 0;
	int     error_count = 0;
	int     tests_passed = 0;
	int     tests_failed = 0;
	int     test_errors_start;
	int     next_tag;
	int     forwarded;
	string  cur_test;

	instr_t    prog [`FILT_CODE_DEPTH]; // Model copy of the loaded program
	pkt_data_t sb_word [int];           // Key is tag*32 + word address
	int        sb_len [int];
	bit        sb_accept [int];
	bit        sb_seen [int];
	int        pending [$];             // Tags still to be snooped

	parallel_filters #(.NUM_VMS(NUM_VMS)) i_parallel_filters (.*);

	initial axi_aclk = 1'b0;
	always #4 axi_aclk = ~axi_aclk;

	always @(posedge axi_aclk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped moving packets", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [63:0] expected,
	                           input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR %s: %s", cur_test, msg);
		error_count++;
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errors_start = error_count;
	endtask

	task automatic end_test();
		if (error_count == test_errors_start) begin
			tests_passed++;
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, error_count - test_errors_start);
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic instr_t make_instr(input opcode_t op, input int addr,
	                                      input logic [31:0] imm);
		instr_t ins;
		ins = '0;
		ins[63:60] = op;
		ins[52:48] = addr[4:0];
		ins[31:0]  = imm;
		return ins;
	endfunction

	// Runs the filter rules on the stored packet
	function automatic bit model_accepts(input int tag);
		int        pc;
		instr_t    ins;
		pkt_data_t w;
		for (pc = 0; pc < `FILT_CODE_DEPTH; pc++) begin
			ins = prog[pc];
			case (ins[63:60])
				OP_ACCEPT: return 1'b1;
				OP_CHECK: begin
					w = sb_word[tag * 32 + int'(ins[52:48])];
					if (w[31:0] != ins[31:0])
						return 1'b0;
				end
				default: return 1'b0;
			endcase
		end
		return 1'b0; // Ran past the last code address
	endfunction

	function automatic int new_packet(input int len);
		int        tag;
		int        a;
		pkt_data_t w;
		tag = next_tag;
		next_tag++;
		for (a = 0; a < len; a++) begin
			w[63:32] = $random(seed);
			w[31:0]  = $random(seed);
			if (a == 0)
				w[63:48] = tag[15:0]; // Tag lives in word 0
			sb_word[tag * 32 + a] = w;
		end
		sb_len[tag]  = len;
		sb_seen[tag] = 1'b0;
		return tag;
	endfunction

	task automatic queue_packet(input int tag);
		sb_accept[tag] = model_accepts(tag);
		pending.push_back(tag);
	endtask

	task automatic load_program(input instr_t code [$]);
		int a;
		repeat (40) @(negedge axi_aclk); // Every engine back in idle
		for (a = 0; a < `FILT_CODE_DEPTH; a++) begin
			prog[a] = (a < code.size()) ? code[a] : '0;
			code_mem_wr_addr = code_addr_t'(a);
			code_mem_wr_data = prog[a];
			code_mem_wr_en   = 1'b1;
			@(negedge axi_aclk);
		end
		code_mem_wr_en = 1'b0;
	endtask

	task automatic send_all();
		int tag;
		int a;
		while (pending.size() > 0) begin
			tag = pending.pop_front();
			for (a = 0; a <= sb_len[tag]; a++) begin
				while (!ready_for_snooper)
					@(negedge axi_aclk);
				if (a < sb_len[tag]) begin
					snooper_wr_addr = pkt_addr_t'(a);
					snooper_wr_data = sb_word[tag * 32 + a];
					snooper_wr_en   = 1'b1;
				end else begin
					snooper_done = 1'b1;
				end
				@(negedge axi_aclk);
				snooper_wr_en = 1'b0;
				snooper_done  = 1'b0;
			end
		end
	endtask

	// Reads one offered packet and checks it against the scoreboard
	task automatic drain_packet();
		int        len;
		int        tag;
		int        a;
		pkt_data_t got [32];
		while (!ready_for_forwarder)
			@(negedge axi_aclk);
		len = int'(len_to_forwarder);
		if (len == 0 || len > 32)
			report_problem($sformatf("offered packet has impossible length %0d", len));
		for (a = 0; a <= len && a <= 32; a++) begin
			if (a > 0)
				got[a-1] = forwarder_rd_data; // Registered read of address a-1
			forwarder_rd_addr = pkt_addr_t'(a);
			forwarder_rd_en   = (a < len && a < 32);
			@(negedge axi_aclk);
		end
		forwarder_done = 1'b1;
		@(negedge axi_aclk);
		forwarder_done = 1'b0;
		tag = int'(got[0][63:48]);
		if (len == 0 || len > 32 || $isunknown(got[0]) || !sb_len.exists(tag)) begin
			report_problem("forwarded packet carries no known tag");
		end else if (!sb_accept[tag]) begin
			report_problem($sformatf("packet %0h was forwarded but should be dropped", tag));
		end else if (sb_seen[tag]) begin
			report_problem($sformatf("packet %0h was forwarded twice", tag));
		end else begin
			sb_seen[tag] = 1'b1;
			forwarded++; // Only distinct packets the model accepts
			check_value($sformatf("length of %0h", tag), sb_len[tag], len);
			for (a = 0; a < len && a < sb_len[tag]; a++)
				check_value($sformatf("word %0d of %0h", a, tag),
				            sb_word[tag * 32 + a], got[a]);
		end
	endtask

	initial begin
		int          i;
		int          tag;
		int          a0;
		int          a1;
		int          expected;
		logic [31:0] imm0;
		logic [31:0] imm1;
		pkt_data_t   w;
		instr_t      code [$];

		rst_n = 1'b0;
		code_mem_wr_addr = '0;
		code_mem_wr_data = '0;
		code_mem_wr_en = 1'b0;
		snooper_wr_addr = '0;
		snooper_wr_data = '0;
		snooper_wr_en = 1'b0;
		snooper_done = 1'b0;
		forwarder_rd_addr = '0;
		forwarder_rd_en = 1'b0;
		forwarder_done = 1'b0;
		next_tag = rand_range(1, 40000);
		repeat (10) @(negedge axi_aclk);
		rst_n = 1'b1;
		@(negedge axi_aclk);

		begin_test("reset");
		check_value("ready_for_snooper", 1, ready_for_snooper);
		check_value("ready_for_forwarder", 0, ready_for_forwarder);
		end_test();

		begin_test("accept_all");
		code.delete();
		code.push_back(make_instr(OP_ACCEPT, 0, 0));
		load_program(code);
		for (i = 0; i < N_ACCEPT; i++)
			queue_packet(new_packet(rand_range(1, 32)));
		forwarded = 0;
		fork
			send_all();
			repeat (N_ACCEPT) drain_packet();
		join
		check_value("forwarded count", N_ACCEPT, forwarded);
		end_test();

		begin_test("reject_all");
		code.delete();
		code.push_back(make_instr(OP_REJECT, 0, 0));
		load_program(code);
		for (i = 0; i < N_REJECT; i++) begin
			queue_packet(new_packet(rand_range(1, 32)));
			send_all();
			repeat (20) @(negedge axi_aclk);
			check_value("ready_for_forwarder", 0, ready_for_forwarder);
			check_value("ready_for_snooper", 1, ready_for_snooper);
		end
		end_test();

		begin_test("check_program");
		a0 = rand_range(0, 31);
		a1 = (a0 + rand_range(1, 31)) % 32;
		imm0 = $random(seed);
		imm1 = $random(seed);
		code.delete();
		code.push_back(make_instr(OP_CHECK, a0, imm0));
		code.push_back(make_instr(OP_CHECK, a1, imm1));
		code.push_back(make_instr(OP_ACCEPT, 0, 0));
		load_program(code);
		expected = 0;
		for (i = 0; i < N_CHECK; i++) begin
			tag = new_packet(rand_range(((a0 > a1) ? a0 : a1) + 1, 32));
			if (rand_range(0, 1) == 1) begin
				w = sb_word[tag * 32 + a0];
				w[31:0] = imm0;
				sb_word[tag * 32 + a0] = w;
				w = sb_word[tag * 32 + a1];
				w[31:0] = imm1;
				sb_word[tag * 32 + a1] = w;
			end
			queue_packet(tag);
			expected += sb_accept[tag];
		end
		forwarded = 0;
		fork
			send_all();
			repeat (expected) drain_packet();
		join
		repeat (40) @(negedge axi_aclk);
		check_value("leftover offer", 0, ready_for_forwarder);
		check_value("forwarded count", expected, forwarded);
		end_test();

		begin_test("back_pressure");
		code.delete();
		code.push_back(make_instr(OP_ACCEPT, 0, 0));
		load_program(code);
		for (i = 0; i < NUM_VMS; i++)
			queue_packet(new_packet(rand_range(1, 32)));
		forwarded = 0;
		send_all();
		repeat (4) @(negedge axi_aclk);
		check_value("ready_for_snooper when full", 0, ready_for_snooper);
		drain_packet();
		check_value("ready_for_snooper after drain", 1, ready_for_snooper);
		repeat (NUM_VMS - 1) drain_packet();
		check_value("forwarded count", NUM_VMS, forwarded);
		end_test();

		$display("Summary: %0d tests passed, %0d failed, %0d assertion failures",
		         tests_passed, tests_failed, i_parallel_filters.i_checker.assert_fails);
		if (error_count == 0 && tests_failed == 0 &&
		    i_parallel_filters.i_checker.assert_fails == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: test/parallel_filters_checker.sv
`timescale 1ns/1ps

module parallel_filters_checker (
	input logic                     axi_aclk,
	input logic                     rst_n,
	input logic                     snooper_wr_en,
	input logic                     snooper_done,
	input logic                     ready_for_snooper,
	input logic                     forwarder_rd_en,
	input logic                     forwarder_done,
	input logic                     ready_for_forwarder,
	input filt_types_pkg::pkt_len_t len_to_forwarder
);
	int assert_fails = 0; // Read by the testbench at the end of the run

	// Snooper strobes need a free engine somewhere below the root
	a_snoop_ready: assert property (@(posedge axi_aclk) disable iff (!rst_n)
		(snooper_wr_en || snooper_done) |-> ready_for_snooper)
		else begin
			assert_fails++;
			$error("snooper strobe while ready_for_snooper is low");
		end

	a_fwd_ready: assert property (@(posedge axi_aclk) disable iff (!rst_n)
		(forwarder_rd_en || forwarder_done) |-> ready_for_forwarder)
		else begin
			assert_fails++;
			$error("forwarder strobe while ready_for_forwarder is low");
		end

	a_snoop_done_pulse: assert property (@(posedge axi_aclk) disable iff (!rst_n)
		snooper_done |=> !snooper_done)
		else begin
			assert_fails++;
			$error("snooper done longer than one cycle");
		end

	a_fwd_done_pulse: assert property (@(posedge axi_aclk) disable iff (!rst_n)
		forwarder_done |=> !forwarder_done)
		else begin
			assert_fails++;
			$error("forwarder done longer than one cycle");
		end

	// Same packet offered two cycles in a row keeps its length
	a_len_stable: assert property (@(posedge axi_aclk) disable iff (!rst_n)
		$past(ready_for_forwarder && !forwarder_done) && ready_for_forwarder
		|-> $stable(len_to_forwarder))
		else begin
			assert_fails++;
			$error("len_to_forwarder changed while a packet was offered");
		end

endmodule

bind parallel_filters parallel_filters_checker i_checker (
	.axi_aclk(axi_aclk),
	.rst_n(rst_n),
	.snooper_wr_en(snooper_wr_en),
	.snooper_done(snooper_done),
	.ready_for_snooper(ready_for_snooper),
	.forwarder_rd_en(forwarder_rd_en),
	.forwarder_done(forwarder_done),
	.ready_for_forwarder(ready_for_forwarder),
	.len_to_forwarder(len_to_forwarder)
);

// File: source/parallel_filters.sv
`timescale 1ns/1ps
`include "filt_macros.svh"

module parallel_filters #(
	parameter int NUM_VMS = `FILT_NUM_VMS // 2 or more
) (
	input  logic                       axi_aclk,
	input  logic                       rst_n,

	input  filt_types_pkg::code_addr_t code_mem_wr_addr,
	input  filt_types_pkg::instr_t     code_mem_wr_data,
	input  logic                       code_mem_wr_en,

	input  filt_types_pkg::pkt_addr_t  snooper_wr_addr,
	input  filt_types_pkg::pkt_data_t  snooper_wr_data,
	input  logic                       snooper_wr_en,
	input  logic                       snooper_done,
	output logic                       ready_for_snooper,

	input  filt_types_pkg::pkt_addr_t  forwarder_rd_addr,
	input  logic                       forwarder_rd_en,
	input  logic                       forwarder_done,
	output filt_types_pkg::pkt_data_t  forwarder_rd_data,
	output logic                       ready_for_forwarder,
	output filt_types_pkg::pkt_len_t   len_to_forwarder
);
	import filt_types_pkg::*;

	// Leaves at 0..NUM_VMS-1, node i at NUM_VMS+i with children 2i and 2i+1
	localparam int NUM_SLOTS = 2 * NUM_VMS - 1;
	localparam int ROOT      = NUM_SLOTS - 1;

	wire pkt_addr_t snp_addr  [NUM_SLOTS];
	wire pkt_data_t snp_data  [NUM_SLOTS];
	wire            snp_wr_en [NUM_SLOTS];
	wire            snp_done  [NUM_SLOTS];
	wire            snp_ready [NUM_SLOTS];

	wire pkt_addr_t fwd_addr  [NUM_SLOTS];
	wire            fwd_rd_en [NUM_SLOTS];
	wire            fwd_done  [NUM_SLOTS];
	wire pkt_data_t fwd_data  [NUM_SLOTS];
	wire            fwd_ready [NUM_SLOTS];
	wire pkt_len_t  fwd_len   [NUM_SLOTS];

	for (genvar i = 0; i < NUM_VMS; i++) begin : g_vm
		filter_vm i_filter_vm (
			.axi_aclk(axi_aclk), .rst_n(rst_n),
			.code_mem_wr_addr(code_mem_wr_addr),
			.code_mem_wr_data(code_mem_wr_data),
			.code_mem_wr_en(code_mem_wr_en),
			.snooper_wr_addr(snp_addr[i]), .snooper_wr_data(snp_data[i]),
			.snooper_wr_en(snp_wr_en[i]), .snooper_done(snp_done[i]),
			.ready_for_snooper(snp_ready[i]),
			.forwarder_rd_addr(fwd_addr[i]), .forwarder_rd_en(fwd_rd_en[i]),
			.forwarder_done(fwd_done[i]), .forwarder_rd_data(fwd_data[i]),
			.ready_for_forwarder(fwd_ready[i]), .len_to_forwarder(fwd_len[i])
		);
	end

	for (genvar i = 0; i < NUM_VMS - 1; i++) begin : g_split
		snoop_split i_snoop_split (
			.axi_aclk(axi_aclk), .rst_n(rst_n),
			.wr_addr(snp_addr[NUM_VMS+i]), .wr_data(snp_data[NUM_VMS+i]),
			.wr_en(snp_wr_en[NUM_VMS+i]), .done(snp_done[NUM_VMS+i]),
			.mem_ready(snp_ready[NUM_VMS+i]),
			.wr_addr_left(snp_addr[2*i]), .wr_data_left(snp_data[2*i]),
			.wr_en_left(snp_wr_en[2*i]), .done_left(snp_done[2*i]),
			.mem_ready_left(snp_ready[2*i]),
			.wr_addr_right(snp_addr[2*i+1]), .wr_data_right(snp_data[2*i+1]),
			.wr_en_right(snp_wr_en[2*i+1]), .done_right(snp_done[2*i+1]),
			.mem_ready_right(snp_ready[2*i+1])
		);
	end

	for (genvar i = 0; i < NUM_VMS - 1; i++) begin : g_combine
		fwd_combine i_fwd_combine (
			.axi_aclk(axi_aclk), .rst_n(rst_n),
			.forwarder_rd_addr(fwd_addr[NUM_VMS+i]), .forwarder_rd_en(fwd_rd_en[NUM_VMS+i]),
			.forwarder_done(fwd_done[NUM_VMS+i]), .forwarder_rd_data(fwd_data[NUM_VMS+i]),
			.ready_for_forwarder(fwd_ready[NUM_VMS+i]), .len_to_forwarder(fwd_len[NUM_VMS+i]),
			.forwarder_rd_addr_left(fwd_addr[2*i]), .forwarder_rd_en_left(fwd_rd_en[2*i]),
			.forwarder_done_left(fwd_done[2*i]), .forwarder_rd_data_left(fwd_data[2*i]),
			.ready_for_forwarder_left(fwd_ready[2*i]), .len_to_forwarder_left(fwd_len[2*i]),
			.forwarder_rd_addr_right(fwd_addr[2*i+1]), .forwarder_rd_en_right(fwd_rd_en[2*i+1]),
			.forwarder_done_right(fwd_done[2*i+1]), .forwarder_rd_data_right(fwd_data[2*i+1]),
			.ready_for_forwarder_right(fwd_ready[2*i+1]),
			.len_to_forwarder_right(fwd_len[2*i+1])
		);
	end

	// Outer ports sit on the two tree roots
	assign snp_addr[ROOT]    = snooper_wr_addr;
	assign snp_data[ROOT]    = snooper_wr_data;
	assign snp_wr_en[ROOT]   = snooper_wr_en;
	assign snp_done[ROOT]    = snooper_done;
	assign ready_for_snooper = snp_ready[ROOT];

	assign fwd_addr[ROOT]      = forwarder_rd_addr;
	assign fwd_rd_en[ROOT]     = forwarder_rd_en;
	assign fwd_done[ROOT]      = forwarder_done;
	assign forwarder_rd_data   = fwd_data[ROOT];
	assign ready_for_forwarder = fwd_ready[ROOT];
	assign len_to_forwarder    = fwd_len[ROOT];

endmodule

// File: source/fwd_combine.sv
`timescale 1ns/1ps

module fwd_combine (
	input  logic                      axi_aclk,
	input  logic                      rst_n,

	input  filt_types_pkg::pkt_addr_t forwarder_rd_addr,
	input  logic                      forwarder_rd_en,
	input  logic                      forwarder_done,
	output filt_types_pkg::pkt_data_t forwarder_rd_data,
	output logic                      ready_for_forwarder,
	output filt_types_pkg::pkt_len_t  len_to_forwarder,

	output filt_types_pkg::pkt_addr_t forwarder_rd_addr_left,
	output logic                      forwarder_rd_en_left,
	output logic                      forwarder_done_left,
	input  filt_types_pkg::pkt_data_t forwarder_rd_data_left,
	input  logic                      ready_for_forwarder_left,
	input  filt_types_pkg::pkt_len_t  len_to_forwarder_left,

	output filt_types_pkg::pkt_addr_t forwarder_rd_addr_right,
	output logic                      forwarder_rd_en_right,
	output logic                      forwarder_done_right,
	input  filt_types_pkg::pkt_data_t forwarder_rd_data_right,
	input  logic                      ready_for_forwarder_right,
	input  filt_types_pkg::pkt_len_t  len_to_forwarder_right
);
	import filt_ctrl_pkg::*;

	route_state_t route;
	route_state_t sel;

	// Left child wins when both hold a packet
	always_comb begin
		if (route != ROUTE_FREE)
			sel = route;
		else if (ready_for_forwarder_left)
			sel = ROUTE_LEFT;
		else if (ready_for_forwarder_right)
			sel = ROUTE_RIGHT;
		else
			sel = ROUTE_FREE;
	end

	assign ready_for_forwarder = (sel == ROUTE_LEFT)  ? ready_for_forwarder_left :
	                             (sel == ROUTE_RIGHT) ? ready_for_forwarder_right : 1'b0;

	assign forwarder_rd_data = (sel == ROUTE_RIGHT) ? forwarder_rd_data_right
	                                                : forwarder_rd_data_left;
	assign len_to_forwarder  = (sel == ROUTE_RIGHT) ? len_to_forwarder_right
	                                                : len_to_forwarder_left;

	assign forwarder_rd_addr_left  = forwarder_rd_addr;
	assign forwarder_rd_addr_right = forwarder_rd_addr;

	assign forwarder_rd_en_left  = forwarder_rd_en && (sel == ROUTE_LEFT);
	assign forwarder_done_left   = forwarder_done && (sel == ROUTE_LEFT);
	assign forwarder_rd_en_right = forwarder_rd_en && (sel == ROUTE_RIGHT);
	assign forwarder_done_right  = forwarder_done && (sel == ROUTE_RIGHT);

	always_ff @(posedge axi_aclk) begin
		if (!rst_n)
			route <= ROUTE_FREE;
		else if (route == ROUTE_FREE)
			route <= sel; // Stays free when no child is ready
		else if (forwarder_done)
			route <= ROUTE_FREE;
	end

endmodule

// File: source/snoop_split.sv
`timescale 1ns/1ps

module snoop_split (
	input  logic                      axi_aclk,
	input  logic                      rst_n,

	input  filt_types_pkg::pkt_addr_t wr_addr,
	input  filt_types_pkg::pkt_data_t wr_data,
	input  logic                      wr_en,
	input  logic                      done,
	output logic                      mem_ready,

	output filt_types_pkg::pkt_addr_t wr_addr_left,
	output filt_types_pkg::pkt_data_t wr_data_left,
	output logic                      wr_en_left,
	output logic                      done_left,
	input  logic                      mem_ready_left,

	output filt_types_pkg::pkt_addr_t wr_addr_right,
	output filt_types_pkg::pkt_data_t wr_data_right,
	output logic                      wr_en_right,
	output logic                      done_right,
	input  logic                      mem_ready_right
);
	import filt_ctrl_pkg::*;

	route_state_t route;
	route_state_t sel;

	// While free the choice is made on the spot so word 0 is not lost
	assign sel = (route != ROUTE_FREE) ? route :
	             mem_ready_left         ? ROUTE_LEFT : ROUTE_RIGHT;

	assign mem_ready = mem_ready_left | mem_ready_right;

	// Address and data go both ways, strobes only to the chosen side
	assign wr_addr_left  = wr_addr;
	assign wr_data_left  = wr_data;
	assign wr_addr_right = wr_addr;
	assign wr_data_right = wr_data;

	assign wr_en_left  = wr_en && (sel == ROUTE_LEFT);
	assign done_left   = done && (sel == ROUTE_LEFT);
	assign wr_en_right = wr_en && (sel == ROUTE_RIGHT);
	assign done_right  = done && (sel == ROUTE_RIGHT);

	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			route <= ROUTE_FREE;
		end else if (route == ROUTE_FREE) begin
			if (wr_en)
				route <= sel; // Held for the rest of the packet
		end else if (done) begin
			route <= ROUTE_FREE;
		end
	end

endmodule

// File: filter_vm/filter_vm.sv
`timescale 1ns/1ps
`include "filt_macros.svh"

module filter_vm (
	input  logic                        axi_aclk,
	input  logic                        rst_n,

	input  filt_types_pkg::code_addr_t  code_mem_wr_addr,
	input  filt_types_pkg::instr_t      code_mem_wr_data,
	input  logic                        code_mem_wr_en,

	input  filt_types_pkg::pkt_addr_t   snooper_wr_addr,
	input  filt_types_pkg::pkt_data_t   snooper_wr_data,
	input  logic                        snooper_wr_en,
	input  logic                        snooper_done, // One-cycle pulse
	output logic                        ready_for_snooper,

	input  filt_types_pkg::pkt_addr_t   forwarder_rd_addr,
	input  logic                        forwarder_rd_en,
	input  logic                        forwarder_done, // One-cycle pulse
	output filt_types_pkg::pkt_data_t   forwarder_rd_data,
	output logic                        ready_for_forwarder,
	output filt_types_pkg::pkt_len_t    len_to_forwarder
);
	import filt_types_pkg::*;
	import filt_ctrl_pkg::*;

	instr_t    code_mem [`FILT_CODE_DEPTH];
	pkt_data_t pkt_mem [`FILT_PKT_DEPTH];

	vm_state_t  state;
	code_addr_t pc;
	instr_t     instr; // Instruction under execution
	pkt_len_t   len;
	pkt_len_t   wr_len;
	logic       snoop_wr;

	opcode_t   op;
	pkt_addr_t op_addr;
	imm_t      op_imm;
	logic      check_ok;

	assign op       = instr[INSTR_OP_LSB +: $bits(opcode_t)];
	assign op_addr  = instr[INSTR_ADDR_LSB +: $bits(pkt_addr_t)];
	assign op_imm   = instr[INSTR_IMM_LSB +: $bits(imm_t)];
	assign check_ok = (pkt_mem[op_addr][$bits(imm_t)-1:0] == op_imm); // Low 32 bits only

	assign ready_for_snooper   = (state == VM_IDLE);
	assign ready_for_forwarder = (state == VM_HOLD);
	assign len_to_forwarder    = len;

	assign snoop_wr = snooper_wr_en && (state == VM_IDLE);
	assign wr_len   = pkt_len_t'(snooper_wr_addr) + pkt_len_t'(1);

	// Program store, same write goes to every engine
	always_ff @(posedge axi_aclk) begin
		if (code_mem_wr_en)
			code_mem[code_mem_wr_addr] <= code_mem_wr_data;
	end

	always_ff @(posedge axi_aclk) begin
		if (snoop_wr)
			pkt_mem[snooper_wr_addr] <= snooper_wr_data;
	end

	// Read data comes one cycle after rd_en
	always_ff @(posedge axi_aclk) begin
		if (forwarder_rd_en)
			forwarder_rd_data <= pkt_mem[forwarder_rd_addr];
	end

	// Word 0 opens a new packet, after that keep the highest address
	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			len <= '0;
		end else if (snoop_wr) begin
			if (snooper_wr_addr == '0)
				len <= pkt_len_t'(1);
			else if (wr_len > len)
				len <= wr_len;
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (state == VM_FETCH)
			instr <= code_mem[pc];
	end

	always_ff @(posedge axi_aclk) begin
		if (!rst_n) begin
			state <= VM_IDLE;
			pc    <= '0;
		end else begin
			case (state)
				VM_IDLE: begin
					if (snooper_done) begin
						state <= VM_FETCH;
						pc    <= '0; // Program always starts at 0
					end
				end
				VM_FETCH: state <= VM_EXEC;
				VM_EXEC: begin
					case (op)
						OP_CHECK: begin
							// Mismatch or falling off the end of code drops the packet
							if (!check_ok || pc == '1) begin
								state <= VM_IDLE;
							end else begin
								pc    <= pc + code_addr_t'(1);
								state <= VM_FETCH;
							end
						end
						OP_ACCEPT: state <= VM_HOLD;
						default:   state <= VM_IDLE; // Reject and unknown opcodes
					endcase
				end
				VM_HOLD: begin
					if (forwarder_done)
						state <= VM_IDLE;
				end
				default: state <= VM_IDLE;
			endcase
		end
	end

endmodule

// File: common/filt_ctrl_pkg.sv
package filt_ctrl_pkg;

	// Filter engine states
	typedef enum logic [1:0] {
		VM_IDLE,  // Free, taking snooped words
		VM_FETCH,
		VM_EXEC,
		VM_HOLD   // Accepted, waiting on forwarder
	} vm_state_t;

	// Route held by a tree node, both directions
	typedef enum logic [1:0] {
		ROUTE_FREE,
		ROUTE_LEFT,
		ROUTE_RIGHT
	} route_state_t;

endpackage

// File: common/filt_types_pkg.sv
`include "filt_macros.svh"

package filt_types_pkg;

	typedef logic [`FILT_ADDR_WIDTH-1:0]      pkt_addr_t;
	typedef logic [`FILT_DATA_WIDTH-1:0]      pkt_data_t;
	typedef logic [`FILT_ADDR_WIDTH:0]        pkt_len_t; // Extra bit so a full buffer fits
	typedef logic [`FILT_CODE_ADDR_WIDTH-1:0] code_addr_t;
	typedef logic [`FILT_INSTR_WIDTH-1:0]     instr_t;
	typedef logic [`FILT_OPCODE_WIDTH-1:0]    opcode_t;
	typedef logic [`FILT_IMM_WIDTH-1:0]       imm_t;

	// Field positions inside an instruction
	localparam int INSTR_OP_LSB   = 60;
	localparam int INSTR_ADDR_LSB = 48;
	localparam int INSTR_IMM_LSB  = 0;

	// Opcodes, anything else behaves as reject
	localparam opcode_t OP_CHECK  = 4'h1;
	localparam opcode_t OP_ACCEPT = 4'h2;
	localparam opcode_t OP_REJECT = 4'h3;

endpackage

// File: common/filt_macros.svh
`ifndef FILT_MACROS_SVH
`define FILT_MACROS_SVH

// Packet buffer, one 64-bit word per address
`define FILT_ADDR_WIDTH 5
`define FILT_DATA_WIDTH 64
`define FILT_PKT_DEPTH (1 << `FILT_ADDR_WIDTH)

// Filter program storage
`define FILT_CODE_ADDR_WIDTH 4
`define FILT_INSTR_WIDTH 64
`define FILT_CODE_DEPTH (1 << `FILT_CODE_ADDR_WIDTH)

// Instruction fields
`define FILT_OPCODE_WIDTH 4
`define FILT_IMM_WIDTH 32

`define FILT_NUM_VMS 4 // Default number of parallel engines

`endif
